// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

  ////////////////////////////////////////
  // Widths and basic types.
  ////////////////////////////////////////
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             word_t;    // Register or PC value.
  typedef logic [31:0]                 insn_t;    // Raw instruction word.
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
  typedef logic [6:0]                  opcode_t;

  localparam word_t PC_STEP  = 32'd4;
  localparam word_t RESET_PC = 32'd0;

  ////////////////////////////////////////
  // Encodings.
  ////////////////////////////////////////
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // ALU funct3, shared by OP and OP-IMM.
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // SRL and SRA.
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA.

endpackage

// File: common/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // Why a stage entry holds what it holds.
  typedef enum logic [1:0] {
    CYCLE_RESET        = 2'd0,
    CYCLE_NO_STALL     = 2'd1,
    CYCLE_TAKEN_BRANCH = 2'd2
  } cycle_status_e;

  ////////////////////////////////////////
  // Stage registers.
  ////////////////////////////////////////
  typedef struct packed {
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::insn_t insn;
    cycle_status_e     status;
  } fd_t;

  typedef struct packed {
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::insn_t    insn;
    cycle_status_e        status;
    rv_isa_pkg::opcode_t  opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    imm;     // Already sign extended.
    rv_isa_pkg::word_t    rs1_val;
    rv_isa_pkg::word_t    rs2_val;
    logic                 we;
  } dx_t;

  // Execute result, also the writeback entry and the trace.
  typedef struct packed {
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::insn_t    insn;
    cycle_status_e        status;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    rd_data;
    logic                 we;
  } xm_t;

  typedef struct packed {
    logic              taken;
    rv_isa_pkg::word_t target;
  } redirect_t;

endpackage

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we_i,
  input  rv_isa_pkg::reg_idx_t rd_i,
  input  rv_isa_pkg::reg_idx_t rs1_i,
  input  rv_isa_pkg::reg_idx_t rs2_i,
  input  rv_isa_pkg::word_t    rd_data_i,
  output rv_isa_pkg::word_t    rs1_data_o,
  output rv_isa_pkg::word_t    rs2_data_o
);

  rv_isa_pkg::word_t regs_q [1:rv_isa_pkg::NUM_REGS-1]; // No storage for x0.

  // Same-cycle write is visible to the read.
  function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_idx_t idx);
    if (idx == '0) begin
      read_port = '0;
    end else if (we_i && rd_i == idx) begin
      read_port = rd_data_i;
    end else begin
      read_port = regs_q[idx];
    end
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs_q[rd_i] <= rd_data_i;
    end
  end

endmodule

// File: core/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
  input  rv_pipe_pkg::fd_t     fd_i,
  output rv_isa_pkg::reg_idx_t rs1_o,
  output rv_isa_pkg::reg_idx_t rs2_o,
  output rv_isa_pkg::reg_idx_t rd_o,
  output rv_isa_pkg::opcode_t  opcode_o,
  output logic [2:0]           funct3_o,
  output logic [6:0]           funct7_o,
  output rv_isa_pkg::word_t    imm_o,
  output logic                 we_o
);

  rv_isa_pkg::insn_t insn;
  logic [2:0]        f3;
  logic [6:0]        f7;
  logic              writes; // Legal encoding of a writing instruction.

  assign insn = fd_i.insn;
  assign f3   = insn[14:12];
  assign f7   = insn[31:25];

  always_comb begin
    rs1_o    = '0;
    rs2_o    = '0;
    rd_o     = '0;
    funct3_o = '0;
    funct7_o = rv_isa_pkg::F7_BASE;
    imm_o    = '0;
    writes   = 1'b0;
    opcode_o = insn[6:0];
    case (opcode_o)
      rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
        rd_o   = insn[11:7];
        imm_o  = {insn[31:12], 12'b0}; // U format.
        writes = 1'b1;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        rd_o     = insn[11:7];
        rs1_o    = insn[19:15];
        funct3_o = f3;
        imm_o    = {{20{insn[31]}}, insn[31:20]};
        if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SR) begin
          // Upper immediate bits select the shift kind.
          funct7_o = f7;
          writes   = (f7 == rv_isa_pkg::F7_BASE) ||
                     (f3 == rv_isa_pkg::F3_SR && f7 == rv_isa_pkg::F7_ALT);
        end else begin
          writes = 1'b1;
        end
      end
      rv_isa_pkg::OPC_OP: begin
        rd_o     = insn[11:7];
        rs1_o    = insn[19:15];
        rs2_o    = insn[24:20];
        funct3_o = f3;
        funct7_o = f7;
        writes   = (f7 == rv_isa_pkg::F7_BASE) || (f7 == rv_isa_pkg::F7_ALT &&
                   (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR));
      end
      rv_isa_pkg::OPC_BRANCH: begin
        rs1_o    = insn[19:15];
        rs2_o    = insn[24:20];
        funct3_o = f3;
        imm_o    = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end
      default: ; // Unknown opcode retires as a bubble.
    endcase
  end

  // Bubbles carry insn 0, which decodes as an unknown opcode.
  assign we_o = writes && (rd_o != '0);

endmodule

// File: core/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode (
  input  logic                   clk,
  input  logic                   rst,
  output rv_isa_pkg::word_t      imem_addr_o,
  input  rv_isa_pkg::insn_t      imem_data_i,
  input  rv_pipe_pkg::redirect_t redirect_i,
  input  rv_pipe_pkg::xm_t       wb_i,
  output rv_pipe_pkg::dx_t       dx_o
);

  rv_isa_pkg::word_t    pc_q;
  rv_pipe_pkg::fd_t     fd_q;
  rv_pipe_pkg::dx_t     dx_q;
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  rv_isa_pkg::reg_idx_t rd;
  rv_isa_pkg::opcode_t  opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  rv_isa_pkg::word_t    imm;
  rv_isa_pkg::word_t    rs1_val;
  rv_isa_pkg::word_t    rs2_val;
  logic                 we;

  ////////////////////////////////////////
  // Fetch.
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= rv_isa_pkg::RESET_PC;
      fd_q <= '{pc: rv_isa_pkg::RESET_PC, insn: '0, status: rv_pipe_pkg::CYCLE_RESET};
    end else if (redirect_i.taken) begin
      pc_q <= redirect_i.target;
      fd_q <= '{pc: pc_q, insn: '0, status: rv_pipe_pkg::CYCLE_TAKEN_BRANCH}; // Squash.
    end else begin
      pc_q <= pc_q + rv_isa_pkg::PC_STEP;
      fd_q <= '{pc: pc_q, insn: imem_data_i, status: rv_pipe_pkg::CYCLE_NO_STALL};
    end
  end

  assign imem_addr_o = pc_q;

  ////////////////////////////////////////
  // Decode.
  ////////////////////////////////////////
  insn_decoder u_insn_decoder (
    .fd_i     (fd_q),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .rd_o     (rd),
    .opcode_o (opcode),
    .funct3_o (funct3),
    .funct7_o (funct7),
    .imm_o    (imm),
    .we_o     (we)
  );

  // Write-through covers the producer three slots ahead.
  reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .we_i       (wb_i.we),
    .rd_i       (wb_i.rd),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_data_i  (wb_i.rd_data),
    .rs1_data_o (rs1_val),
    .rs2_data_o (rs2_val)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      dx_q <= '{status: rv_pipe_pkg::CYCLE_RESET, default: '0};
    end else if (redirect_i.taken) begin
      dx_q <= '{pc: fd_q.pc, status: rv_pipe_pkg::CYCLE_TAKEN_BRANCH, default: '0};
    end else begin
      dx_q <= '{pc: fd_q.pc, insn: fd_q.insn, status: fd_q.status, opcode: opcode,
                funct3: funct3, funct7: funct7, rs1: rs1, rs2: rs2, rd: rd, imm: imm,
                rs1_val: rs1_val, rs2_val: rs2_val, we: we};
    end
  end

  assign dx_o = dx_q;

endmodule

// File: core/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pipe_pkg::dx_t       dx_i,
  input  rv_pipe_pkg::xm_t       wb_i,
  output rv_pipe_pkg::redirect_t redirect_o,
  output rv_pipe_pkg::xm_t       xm_o
);

  rv_pipe_pkg::xm_t  xm_q;
  rv_isa_pkg::word_t op_a;     // Forwarded rs1.
  rv_isa_pkg::word_t rs2_fwd;  // Forwarded rs2.
  rv_isa_pkg::word_t op_b;
  rv_isa_pkg::word_t result;
  logic [4:0]        shamt;
  logic              is_op;
  logic              alu_ok;
  logic              br_cond;

  ////////////////////////////////////////
  // Forwarding.
  ////////////////////////////////////////
  // Memory entry is younger, so it wins.
  function automatic rv_isa_pkg::word_t fwd_sel(input rv_isa_pkg::reg_idx_t idx,
                                                input rv_isa_pkg::word_t    rf_val,
                                                input rv_pipe_pkg::xm_t     mem,
                                                input rv_pipe_pkg::xm_t     wb);
    if (mem.we && mem.rd != '0 && mem.rd == idx) begin
      fwd_sel = mem.rd_data;
    end else if (wb.we && wb.rd != '0 && wb.rd == idx) begin
      fwd_sel = wb.rd_data;
    end else begin
      fwd_sel = rf_val;
    end
  endfunction

  assign op_a    = fwd_sel(dx_i.rs1, dx_i.rs1_val, xm_q, wb_i);
  assign rs2_fwd = fwd_sel(dx_i.rs2, dx_i.rs2_val, xm_q, wb_i);
  assign is_op   = (dx_i.opcode == rv_isa_pkg::OPC_OP);
  assign op_b    = is_op ? rs2_fwd : dx_i.imm;
  assign shamt   = op_b[4:0]; // Low 5 bits only.

  ////////////////////////////////////////
  // ALU.
  ////////////////////////////////////////
  always_comb begin
    result = '0;
    alu_ok = 1'b1;
    case (dx_i.opcode)
      rv_isa_pkg::OPC_LUI:   result = dx_i.imm;
      rv_isa_pkg::OPC_AUIPC: result = dx_i.pc + dx_i.imm;
      rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP: begin
        case (dx_i.funct3)
          rv_isa_pkg::F3_ADD: begin
            if (is_op && dx_i.funct7 == rv_isa_pkg::F7_ALT) begin
              result = op_a - op_b; // SUB.
            end else begin
              result = op_a + op_b;
            end
          end
          rv_isa_pkg::F3_SLL:  result = op_a << shamt;
          rv_isa_pkg::F3_SLT:  result = rv_isa_pkg::word_t'($signed(op_a) < $signed(op_b));
          rv_isa_pkg::F3_SLTU: result = rv_isa_pkg::word_t'(op_a < op_b);
          rv_isa_pkg::F3_XOR:  result = op_a ^ op_b;
          rv_isa_pkg::F3_SR: begin
            if (dx_i.funct7 == rv_isa_pkg::F7_ALT) begin
              result = $signed(op_a) >>> shamt; // Arithmetic.
            end else begin
              result = op_a >> shamt;
            end
          end
          rv_isa_pkg::F3_OR:   result = op_a | op_b;
          default:             result = op_a & op_b; // AND.
        endcase
        alu_ok = (dx_i.funct7 == rv_isa_pkg::F7_BASE) ||
                 (dx_i.funct7 == rv_isa_pkg::F7_ALT && (dx_i.funct3 == rv_isa_pkg::F3_SR ||
                  (is_op && dx_i.funct3 == rv_isa_pkg::F3_ADD)));
      end
      default: alu_ok = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Branch resolution.
  ////////////////////////////////////////
  always_comb begin
    br_cond = 1'b0;
    if (dx_i.opcode == rv_isa_pkg::OPC_BRANCH) begin
      case (dx_i.funct3)
        rv_isa_pkg::F3_BEQ:  br_cond = (op_a == rs2_fwd);
        rv_isa_pkg::F3_BNE:  br_cond = (op_a != rs2_fwd);
        rv_isa_pkg::F3_BLT:  br_cond = ($signed(op_a) < $signed(rs2_fwd));
        rv_isa_pkg::F3_BGE:  br_cond = ($signed(op_a) >= $signed(rs2_fwd));
        rv_isa_pkg::F3_BLTU: br_cond = (op_a < rs2_fwd);
        rv_isa_pkg::F3_BGEU: br_cond = (op_a >= rs2_fwd);
        default:             br_cond = 1'b0; // Reserved funct3 never taken.
      endcase
    end
  end

  assign redirect_o.taken  = br_cond;
  assign redirect_o.target = dx_i.pc + dx_i.imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      xm_q <= '{status: rv_pipe_pkg::CYCLE_RESET, default: '0};
    end else begin
      xm_q <= '{pc: dx_i.pc, insn: dx_i.insn, status: dx_i.status, rd: dx_i.rd,
                rd_data: result, we: dx_i.we && alu_ok && !br_cond};
    end
  end

  assign xm_o = xm_q;

endmodule

// File: core/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                clk,
  input  logic                rst,
  output rv_isa_pkg::word_t   imem_addr_o,
  input  rv_isa_pkg::insn_t   imem_data_i,
  output rv_pipe_pkg::xm_t    trace_wb_o
);

  rv_pipe_pkg::redirect_t redirect;
  rv_pipe_pkg::dx_t       dx;
  rv_pipe_pkg::xm_t       xm;
  rv_pipe_pkg::xm_t       wb_q;

  ////////////////////////////////////////
  // Fetch and decode.
  ////////////////////////////////////////
  fetch_decode u_fetch_decode (
    .clk         (clk),
    .rst         (rst),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .redirect_i  (redirect),
    .wb_i        (wb_q),     // Register file write port.
    .dx_o        (dx)
  );

  ////////////////////////////////////////
  // Execute.
  ////////////////////////////////////////
  execute_stage u_execute_stage (
    .clk        (clk),
    .rst        (rst),
    .dx_i       (dx),
    .wb_i       (wb_q),      // Second forwarding source.
    .redirect_o (redirect),
    .xm_o       (xm)
  );

  ////////////////////////////////////////
  // Memory to writeback.
  ////////////////////////////////////////
  // No data memory, so the memory stage only delays the result.
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q <= '{status: rv_pipe_pkg::CYCLE_RESET, default: '0};
    end else begin
      wb_q <= xm;
    end
  end

  // Retiring entry.
  assign trace_wb_o = wb_q;

endmodule

// File: tb/rv_core_chk.sv
`timescale 1ns/1ps

module rv_core_chk (
  input logic                   clk,
  input logic                   rst,
  input rv_isa_pkg::word_t      imem_addr_i,
  input rv_pipe_pkg::xm_t       trace_i,
  input rv_pipe_pkg::redirect_t redirect_i
);

  // Only real, legal instructions may write, and never x0.
  a_we_legal: assert property (@(posedge clk) disable iff (rst)
    trace_i.we |-> (trace_i.status == rv_pipe_pkg::CYCLE_NO_STALL && trace_i.rd != '0))
    else $error("trace write from a non-retiring entry or to x0");

  a_fetch_aligned: assert property (@(posedge clk) disable iff (rst)
    imem_addr_i[1:0] == 2'b00)
    else $error("fetch address is not word aligned");

  ////////////////////////////////////////
  // Squash after a taken branch.
  ////////////////////////////////////////
  // Branch retires 2 cycles later and its two bubbles at 3 and 4.
  a_squash: assert property (@(posedge clk) disable iff (rst)
    redirect_i.taken |->
      ##3 (trace_i.status == rv_pipe_pkg::CYCLE_TAKEN_BRANCH && !trace_i.we)
      ##1 (trace_i.status == rv_pipe_pkg::CYCLE_TAKEN_BRANCH && !trace_i.we))
    else $error("taken branch not followed by two squashed bubbles");

endmodule

bind rv_core rv_core_chk u_rv_core_chk (
  .clk         (clk),
  .rst         (rst),
  .imem_addr_i (imem_addr_o),
  .trace_i     (trace_wb_o),
  .redirect_i  (redirect)
);

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int MEM_WORDS = 512;
  localparam int CLK_HALF  = 5;

  // One expected trace entry.
  typedef struct packed {
    logic                 bubble;
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::insn_t    insn;
    logic                 we;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    data;
  } exp_t;

  logic              clk;
  logic              rst;
  rv_isa_pkg::word_t imem_addr;
  rv_isa_pkg::insn_t imem_data;
  rv_pipe_pkg::xm_t  trace;

  rv_isa_pkg::insn_t mem [MEM_WORDS]; // Program words.
  rv_isa_pkg::word_t regs [32];       // Reference register state.
  exp_t              exp_q [$];
  int                prog_len;
  int                cycle_budget;
  int                errors;
  int                seed;
  string             test_name;

  rv_core dut (
    .clk         (clk),
    .rst         (rst),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .trace_wb_o  (trace)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////
  // Reporting.
  ////////////////////////////////////////
  task automatic abort_run(input string reason);
    errors++;
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("mismatch %s %s: expected %h, actual %h",
                          test_name, what, expected, actual));
    end
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > cycle_budget) begin
        abort_run($sformatf("Timeout in test %s: no finish within %0d cycles (%0d ns)",
                            test_name, cycle_budget, cycle_budget * 10));
      end
    end
  end

  ////////////////////////////////////////
  // Instruction encoders.
  ////////////////////////////////////////
  function automatic rv_isa_pkg::insn_t rtype(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
  endfunction

  function automatic rv_isa_pkg::insn_t itype(input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
  endfunction

  function automatic rv_isa_pkg::insn_t utype(input rv_isa_pkg::opcode_t opc,
                                              input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic rv_isa_pkg::insn_t btype(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
  endfunction

  ////////////////////////////////////////
  // Memory model and stimulus.
  ////////////////////////////////////////
  function automatic rv_isa_pkg::insn_t fetch_word(input rv_isa_pkg::word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog_len) begin
      return mem[idx];
    end
    return {addr[26:2] ^ {20'b0, addr[31:27]}, 7'h7f}; // Unknown opcode past the end.
  endfunction

  task automatic tick();
    @(negedge clk);
    imem_data = fetch_word(imem_addr);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    prog_len  = 0;
  endtask

  task automatic emit(input rv_isa_pkg::insn_t insn);
    if (prog_len >= MEM_WORDS) begin
      abort_run($sformatf("Program of test %s does not fit in memory", test_name));
    end
    mem[prog_len] = insn;
    prog_len++;
  endtask

  task automatic pulse_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (8) begin
      tick();
      check_eq("reset we", 32'd0, 32'(trace.we));
      check_eq("reset status", 32'(rv_pipe_pkg::CYCLE_RESET), 32'(trace.status));
      check_eq("reset fetch address", 32'd0, imem_addr);
    end
    rst = 1'b0;
  endtask

  ////////////////////////////////////////
  // Reference model.
  ////////////////////////////////////////
  function automatic rv_isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                input rv_isa_pkg::word_t a,
                                                input rv_isa_pkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    if (f3 == rv_isa_pkg::F3_ADD) begin
      if (alt) return a - b;
      return a + b;
    end
    if (f3 == rv_isa_pkg::F3_SLL) return a << sh;
    if (f3 == rv_isa_pkg::F3_SLT) return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    if (f3 == rv_isa_pkg::F3_SLTU) return (a < b) ? 32'd1 : 32'd0;
    if (f3 == rv_isa_pkg::F3_XOR) return a ^ b;
    if (f3 == rv_isa_pkg::F3_SR) begin
      if (alt) return rv_isa_pkg::word_t'($signed(a) >>> sh);
      return a >> sh;
    end
    if (f3 == rv_isa_pkg::F3_OR) return a | b;
    return a & b;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input rv_isa_pkg::word_t a,
                                      input rv_isa_pkg::word_t b);
    case (f3)
      rv_isa_pkg::F3_BEQ:  return a == b;
      rv_isa_pkg::F3_BNE:  return a != b;
      rv_isa_pkg::F3_BLT:  return $signed(a) < $signed(b);
      rv_isa_pkg::F3_BGE:  return $signed(a) >= $signed(b);
      rv_isa_pkg::F3_BLTU: return a < b;
      rv_isa_pkg::F3_BGEU: return a >= b;
      default:             return 1'b0;
    endcase
  endfunction

  // Walks the program in order and queues the expected trace.
  task automatic model_run();
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::insn_t insn;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              taken;
    exp_t              e;
    int                steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    exp_q.delete();
    pc    = '0;
    steps = 0;
    while (int'(pc >> 2) < prog_len && steps < 4 * MEM_WORDS) begin
      insn  = mem[int'(pc >> 2)];
      f3    = insn[14:12];
      f7    = insn[31:25];
      a     = regs[insn[19:15]];
      b     = regs[insn[24:20]];
      taken = 1'b0;
      e = '{bubble: 1'b0, pc: pc, insn: insn, we: 1'b0, rd: insn[11:7], data: '0};
      case (insn[6:0])
        rv_isa_pkg::OPC_LUI: begin
          e.we   = 1'b1;
          e.data = {insn[31:12], 12'b0};
        end
        rv_isa_pkg::OPC_AUIPC: begin
          e.we   = 1'b1;
          e.data = pc + {insn[31:12], 12'b0};
        end
        rv_isa_pkg::OPC_OP_IMM: begin
          if (f3 == rv_isa_pkg::F3_SLL) begin
            e.we = (f7 == rv_isa_pkg::F7_BASE);
          end else if (f3 == rv_isa_pkg::F3_SR) begin
            e.we = (f7 == rv_isa_pkg::F7_BASE) || (f7 == rv_isa_pkg::F7_ALT);
          end else begin
            e.we = 1'b1;
          end
          e.data = alu_ref(f3, f3 == rv_isa_pkg::F3_SR && f7 == rv_isa_pkg::F7_ALT, a,
                           {{20{insn[31]}}, insn[31:20]});
        end
        rv_isa_pkg::OPC_OP: begin
          e.we = (f7 == rv_isa_pkg::F7_BASE) || (f7 == rv_isa_pkg::F7_ALT &&
                 (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR));
          e.data = alu_ref(f3, f7 == rv_isa_pkg::F7_ALT, a, b);
        end
        rv_isa_pkg::OPC_BRANCH: taken = branch_ref(f3, a, b);
        default: ;
      endcase
      if (e.rd == '0) e.we = 1'b0;
      if (e.we) regs[e.rd] = e.data;
      exp_q.push_back(e);
      if (taken) begin
        e.bubble = 1'b1; // Two squashed slots.
        exp_q.push_back(e);
        exp_q.push_back(e);
        pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end else begin
        pc = pc + 32'd4;
      end
      steps++;
    end
  endtask

  task automatic compare_entry(input exp_t e);
    if (e.bubble) begin
      check_eq("bubble status", 32'(rv_pipe_pkg::CYCLE_TAKEN_BRANCH), 32'(trace.status));
      check_eq("bubble we", 32'd0, 32'(trace.we));
      check_eq("bubble insn", 32'd0, trace.insn);
    end else begin
      check_eq("status", 32'(rv_pipe_pkg::CYCLE_NO_STALL), 32'(trace.status));
      check_eq("pc", e.pc, trace.pc);
      check_eq($sformatf("insn at pc %h", e.pc), e.insn, trace.insn);
      check_eq($sformatf("we at pc %h", e.pc), 32'(e.we), 32'(trace.we));
      if (e.we) begin
        check_eq($sformatf("rd at pc %h", e.pc), 32'(e.rd), 32'(trace.rd));
        check_eq($sformatf("rd_data at pc %h", e.pc), e.data, trace.rd_data);
      end
    end
  endtask

  // Reset, then match every retiring entry against the model.
  task automatic run_program();
    logic started;
    cycle_budget += prog_len + 20;
    model_run();
    pulse_reset();
    started = 1'b0;
    while (exp_q.size() > 0) begin
      if (trace.status == rv_pipe_pkg::CYCLE_RESET) begin
        if (started) begin
          abort_run($sformatf("Test %s: reset entry on the trace after retiring began",
                              test_name));
        end
        check_eq("reset we", 32'd0, 32'(trace.we));
      end else begin
        started = 1'b1;
        compare_entry(exp_q.pop_front());
      end
      tick();
    end
  endtask

  ////////////////////////////////////////
  // Directed tests.
  ////////////////////////////////////////
  task automatic test_reset();
    begin_test("reset");
    for (int i = 0; i < 8; i++) begin
      emit(itype(rv_isa_pkg::F3_ADD, 5'd1, 5'd0, 12'(i)));
    end
    cycle_budget += prog_len + 20;
    pulse_reset();
    for (int k = 0; k < 8; k++) begin
      check_eq("fetch address", 32'(4 * k), imem_addr);
      if (k < 4) begin
        check_eq("we after reset", 32'd0, 32'(trace.we));
        check_eq("status after reset", 32'(rv_pipe_pkg::CYCLE_RESET), 32'(trace.status));
      end
      tick();
    end
  endtask

  task automatic test_immediate();
    begin_test("immediate");
    emit(utype(rv_isa_pkg::OPC_LUI, 5'd1, 20'h80000));
    emit(utype(rv_isa_pkg::OPC_AUIPC, 5'd2, 20'h00012));
    emit(itype(rv_isa_pkg::F3_ADD, 5'd3, 5'd0, 12'hff0));  // x3 = -16.
    emit(itype(rv_isa_pkg::F3_ADD, 5'd4, 5'd3, 12'h7ff));
    emit(itype(rv_isa_pkg::F3_SLT, 5'd5, 5'd3, 12'hfff));
    emit(itype(rv_isa_pkg::F3_SLTU, 5'd6, 5'd3, 12'hfff));
    emit(itype(rv_isa_pkg::F3_XOR, 5'd7, 5'd3, 12'h5a5));
    emit(itype(rv_isa_pkg::F3_OR, 5'd8, 5'd4, 12'h0f0));
    emit(itype(rv_isa_pkg::F3_AND, 5'd9, 5'd3, 12'h8ff));
    emit(itype(rv_isa_pkg::F3_SLL, 5'd10, 5'd3, 12'h004));
    emit(itype(rv_isa_pkg::F3_SR, 5'd11, 5'd1, 12'h01f));  // SRLI by 31.
    emit(itype(rv_isa_pkg::F3_SR, 5'd12, 5'd1, 12'h41f));  // SRAI by 31.
    emit(itype(rv_isa_pkg::F3_SR, 5'd13, 5'd3, 12'h404));
    emit(itype(rv_isa_pkg::F3_SR, 5'd14, 5'd3, 12'h004));
    emit(itype(rv_isa_pkg::F3_SLTU, 5'd15, 5'd14, 12'h000));
    run_program();
  endtask

  task automatic test_forwarding();
    begin_test("forwarding");
    emit(itype(rv_isa_pkg::F3_ADD, 5'd1, 5'd0, 12'h064));
    emit(itype(rv_isa_pkg::F3_ADD, 5'd2, 5'd0, 12'hff9));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 5'd3, 5'd1, 5'd2)); // Distances 1, 2.
    emit(rtype(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD, 5'd4, 5'd3, 5'd1));  // Distances 1, 3.
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, 5'd5, 5'd3, 5'd4));
    emit(itype(rv_isa_pkg::F3_ADD, 5'd0, 5'd0, 12'h000));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR, 5'd6, 5'd4, 5'd3));  // Distances 3, 4.
    emit(itype(rv_isa_pkg::F3_ADD, 5'd0, 5'd1, 12'h037));                  // Write to x0.
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 5'd7, 5'd0, 5'd6));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL, 5'd8, 5'd2, 5'd1));
    emit(rtype(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SR, 5'd9, 5'd2, 5'd1));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SR, 5'd10, 5'd2, 5'd1));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT, 5'd11, 5'd2, 5'd1));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLTU, 5'd12, 5'd2, 5'd1));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND, 5'd13, 5'd9, 5'd10));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 5'd0, 5'd13, 5'd13));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 5'd14, 5'd0, 5'd13));
    run_program();
  endtask

  // Branch over two accumulating writes, which must vanish when taken.
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [11:0] tag);
    emit(btype(f3, rs1, rs2, 13'd12));
    emit(itype(rv_isa_pkg::F3_ADD, 5'd10, 5'd10, tag));
    emit(itype(rv_isa_pkg::F3_ADD, 5'd11, 5'd11, tag));
  endtask

  task automatic test_branches();
    begin_test("branches");
    emit(itype(rv_isa_pkg::F3_ADD, 5'd1, 5'd0, 12'hfff)); // x1 = -1.
    emit(itype(rv_isa_pkg::F3_ADD, 5'd2, 5'd0, 12'h001));
    emit(itype(rv_isa_pkg::F3_ADD, 5'd3, 5'd0, 12'h001));
    branch_case(rv_isa_pkg::F3_BEQ, 5'd2, 5'd3, 12'h001);
    branch_case(rv_isa_pkg::F3_BEQ, 5'd1, 5'd2, 12'h002);
    branch_case(rv_isa_pkg::F3_BNE, 5'd1, 5'd2, 12'h004);
    branch_case(rv_isa_pkg::F3_BNE, 5'd2, 5'd3, 12'h008);
    branch_case(rv_isa_pkg::F3_BLT, 5'd1, 5'd2, 12'h010);
    branch_case(rv_isa_pkg::F3_BLT, 5'd2, 5'd1, 12'h020);
    branch_case(rv_isa_pkg::F3_BGE, 5'd2, 5'd1, 12'h040);
    branch_case(rv_isa_pkg::F3_BGE, 5'd1, 5'd2, 12'h080);
    branch_case(rv_isa_pkg::F3_BLTU, 5'd2, 5'd1, 12'h100);
    branch_case(rv_isa_pkg::F3_BLTU, 5'd1, 5'd2, 12'h200);
    branch_case(rv_isa_pkg::F3_BGEU, 5'd1, 5'd2, 12'h400);
    branch_case(rv_isa_pkg::F3_BGEU, 5'd2, 5'd1, 12'h033);
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 5'd12, 5'd10, 5'd11));
    run_program();
  endtask

  task automatic test_random_alu();
    logic [31:0] bits;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    begin_test("random_alu");
    seed = 32'h3195f749;
    for (int n = 0; n < 200; n++) begin
      bits = $random(seed);
      f3   = bits[11:9];
      imm  = bits[23:12];
      if (bits[24]) begin
        f7 = (bits[25] && (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR)) ?
             rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
        emit(rtype(f7, f3, {2'b0, bits[2:0]}, {2'b0, bits[5:3]}, {2'b0, bits[8:6]}));
      end else begin
        if (f3 == rv_isa_pkg::F3_SLL) begin
          imm[11:5] = rv_isa_pkg::F7_BASE;
        end else if (f3 == rv_isa_pkg::F3_SR) begin
          imm[11:5] = bits[25] ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
        end
        emit(itype(f3, {2'b0, bits[2:0]}, {2'b0, bits[5:3]}, imm));
      end
    end
    run_program();
  endtask

  task automatic test_illegal();
    begin_test("illegal");
    emit(itype(rv_isa_pkg::F3_ADD, 5'd1, 5'd0, 12'h005));
    emit(32'h123450ff);                                    // Unknown opcode, rd x1.
    emit(itype(rv_isa_pkg::F3_SLL, 5'd2, 5'd1, 12'h023));   // SLLI with funct7 1.
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 5'd3, 5'd1, 5'd1));
    emit(itype(rv_isa_pkg::F3_ADD, 5'd2, 5'd2, 12'h001));
    emit(rtype(7'h01, rv_isa_pkg::F3_ADD, 5'd4, 5'd1, 5'd1));
    emit(rtype(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 5'd5, 5'd4, 5'd3));
    run_program();
  endtask

  initial begin
    rst          = 1'b1;
    imem_data    = '0;
    errors       = 0;
    cycle_budget = 0;
    prog_len     = 0;
    seed         = 32'h3195f749;
    test_name    = "startup";
    test_reset();
    test_immediate();
    test_forwarding();
    test_branches();
    test_random_alu();
    test_illegal();
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: rv_core.f
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
design/reg_file.sv
core/insn_decoder.sv
core/fetch_decode.sv
core/execute_stage.sv
core/rv_core.sv
tb/rv_core_chk.sv
tb/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rv_core -Mdir obj_dir -f rv_core.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rv_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
